/* src/fault_isolator.sv */
// fault_isolator: channel gating, handshake strobes and sticky fault latch
`default_nettype none

module fault_isolator (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         guard_ena_i,
  input  logic                         aw_valid_i,
  input  write_guard_pkg::id_t         aw_id_i,
  output logic                         aw_ready_o,
  input  logic                         w_valid_i,
  input  logic                         w_last_i,
  output logic                         w_ready_o,
  output logic                         b_valid_o,
  output write_guard_pkg::id_t         b_id_o,
  input  logic                         b_ready_i,
  output logic                         slv_aw_valid_o,
  output write_guard_pkg::id_t         slv_aw_id_o,
  input  logic                         slv_aw_ready_i,
  output logic                         slv_w_valid_o,
  output logic                         slv_w_last_o,
  input  logic                         slv_w_ready_i,
  input  logic                         slv_b_valid_i,
  input  write_guard_pkg::id_t         slv_b_id_i,
  output logic                         slv_b_ready_o,
  input  logic                         full_i,
  input  logic                         order_empty_i,
  input  logic                         fault_i,
  input  write_guard_pkg::fault_kind_t fault_kind_i,
  input  write_guard_pkg::fault_info_u fault_info_i,
  output logic                         aw_pending_o,
  output logic                         aw_fire_o,
  output logic                         w_last_fire_o,
  output logic                         b_fire_o,
  output logic                         irq_o,
  output logic                         reset_req_o,
  output write_guard_pkg::fault_kind_t fault_kind_o,
  output write_guard_pkg::fault_info_u fault_info_o
);

  logic fault_q, isolate, track, aw_hold, w_hold;

  assign isolate = guard_ena_i & fault_q;
  assign track = guard_ena_i & ~fault_q;
  assign aw_hold = track & full_i;
  // no address waiting for data yet
  assign w_hold = track & order_empty_i;

  // isolated: slave sees nothing, master drains freely
  assign slv_aw_valid_o = aw_valid_i & ~aw_hold & ~isolate;
  assign aw_ready_o = isolate | (slv_aw_ready_i & ~aw_hold);
  assign slv_w_valid_o = w_valid_i & ~w_hold & ~isolate;
  assign w_ready_o = isolate | (slv_w_ready_i & ~w_hold);
  assign b_valid_o = slv_b_valid_i & ~isolate;
  assign slv_b_ready_o = isolate | b_ready_i;

  assign slv_aw_id_o = aw_id_i;
  assign slv_w_last_o = w_last_i;
  assign b_id_o = slv_b_id_i;

  assign aw_pending_o = track & aw_valid_i & ~aw_ready_o;
  assign aw_fire_o = track & slv_aw_valid_o & slv_aw_ready_i;
  assign w_last_fire_o = track & slv_w_valid_o & slv_w_ready_i & w_last_i;
  assign b_fire_o = track & b_valid_o & b_ready_i;

  // first fault wins, held until reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fault_q <= 1'b0;
      fault_kind_o <= write_guard_pkg::FK_NONE;
      fault_info_o <= '0;
    end else if (track && fault_i) begin
      fault_q <= 1'b1;
      fault_kind_o <= fault_kind_i;
      fault_info_o <= fault_info_i;
    end
  end

  assign irq_o = fault_q;
  assign reset_req_o = fault_q;

endmodule

`default_nettype wire

/* src/id_queue.sv */
// head-tail table and linked slot pool keyed by write id
`default_nettype none

`include "write_guard_settings.svh"

module id_queue (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      push_i,
  input  write_guard_pkg::id_t      push_id_i,
  input  logic                      pop_i,
  input  write_guard_pkg::id_t      pop_id_i,
  output write_guard_pkg::slot_idx_t alloc_slot_o,
  output logic                      full_o,
  output logic                      pop_hit_o,
  output write_guard_pkg::slot_idx_t pop_slot_o
);

  localparam int unsigned num_slots = `WG_MAX_TXNS;
  localparam int unsigned num_ids = `WG_MAX_IDS;
  localparam int unsigned ht_idx_width = (num_ids > 1) ? $clog2(num_ids) : 1;

  typedef logic [ht_idx_width-1:0] ht_idx_t;

  typedef struct packed {
    write_guard_pkg::id_t      id;
    write_guard_pkg::slot_idx_t head;
    write_guard_pkg::slot_idx_t tail;
    logic                      free;
  } head_tail_t;

  head_tail_t [num_ids-1:0]    ht_q, ht_d;
  logic [num_slots-1:0]        used_q, used_d;
  write_guard_pkg::slot_idx_t  next_q [num_slots];
  write_guard_pkg::slot_idx_t  next_d [num_slots];

  logic    push_match, pop_match, ht_full, pop_frees;
  ht_idx_t push_idx, pop_idx, free_idx, open_idx;

  // id lookup and priority search with the lowest index winning
  always_comb begin
    push_match = 1'b0;
    push_idx = '0;
    pop_match = 1'b0;
    pop_idx = '0;
    free_idx = '0;
    ht_full = 1'b1;
    for (int i = num_ids - 1; i >= 0; i--) begin
      if (!ht_q[i].free && (ht_q[i].id == push_id_i)) begin
        push_match = 1'b1;
        push_idx = ht_idx_t'(i);
      end
      if (!ht_q[i].free && (ht_q[i].id == pop_id_i)) begin
        pop_match = 1'b1;
        pop_idx = ht_idx_t'(i);
      end
      if (ht_q[i].free) begin
        ht_full = 1'b0;
        free_idx = ht_idx_t'(i);
      end
    end
    alloc_slot_o = '0;
    for (int i = num_slots - 1; i >= 0; i--) begin
      if (!used_q[i]) begin
        alloc_slot_o = write_guard_pkg::slot_idx_t'(i);
      end
    end
  end

  // a full id table only blocks an id that has no list yet
  assign full_o = (&used_q) | (ht_full & ~push_match);
  assign pop_hit_o = pop_match;
  assign pop_slot_o = ht_q[pop_idx].head;
  assign pop_frees = pop_i && pop_match && (ht_q[pop_idx].head == ht_q[pop_idx].tail);
  // a list emptied this cycle is reopened in place
  assign open_idx = push_match ? push_idx : free_idx;

  always_comb begin
    ht_d = ht_q;
    used_d = used_q;
    next_d = next_q;
    if (pop_i && pop_match) begin
      used_d[ht_q[pop_idx].head] = 1'b0;
      if (pop_frees) begin
        ht_d[pop_idx].free = 1'b1;
      end else begin
        ht_d[pop_idx].head = next_q[ht_q[pop_idx].head];
      end
    end
    if (push_i) begin
      used_d[alloc_slot_o] = 1'b1;
      if (push_match && !(pop_frees && (push_idx == pop_idx))) begin
        // append behind the current tail
        next_d[ht_q[push_idx].tail] = alloc_slot_o;
        ht_d[push_idx].tail = alloc_slot_o;
      end else begin
        ht_d[open_idx] = '{id: push_id_i, head: alloc_slot_o, tail: alloc_slot_o,
                           free: 1'b0};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < num_ids; i++) begin
        ht_q[i] <= '{free: 1'b1, default: '0};
      end
      used_q <= '0;
    end else begin
      ht_q <= ht_d;
      used_q <= used_d;
    end
  end

  // next pointer of each slot within its id list
  always_ff @(posedge clk_i) begin
    next_q <= next_d;
  end

endmodule

`default_nettype wire

/* src/phase_watchdog.sv */
// phase_watchdog: per-slot phase and latency counters, timeout and unexpected response detection
`default_nettype none

`include "write_guard_settings.svh"

module phase_watchdog (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         aw_pending_i,
  input  logic                         aw_fire_i,
  input  write_guard_pkg::slot_idx_t   alloc_slot_i,
  input  logic                         w_last_fire_i,
  input  write_guard_pkg::slot_idx_t   data_slot_i,
  input  logic                         b_fire_i,
  input  write_guard_pkg::id_t         b_id_i,
  input  logic                         pop_hit_i,
  input  write_guard_pkg::slot_idx_t   pop_slot_i,
  input  write_guard_pkg::cnt_t        budget_aw_i,
  input  write_guard_pkg::cnt_t        budget_w_i,
  input  write_guard_pkg::cnt_t        budget_b_i,
  output logic                         fault_o,
  output write_guard_pkg::fault_kind_t fault_kind_o,
  output write_guard_pkg::fault_info_u fault_info_o
);

  localparam int unsigned num_slots = `WG_MAX_TXNS;

  write_guard_pkg::phase_t phase_q [num_slots];
  write_guard_pkg::cnt_t   cnt_q [num_slots];
  write_guard_pkg::cnt_t   aw_cnt_q;
  logic                    unexpected_b;

  // response must match the head slot of its id, and that slot must await B
  assign unexpected_b = b_fire_i &&
                        !(pop_hit_i && (phase_q[pop_slot_i] == write_guard_pkg::PH_RESP));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < num_slots; i++) begin
        phase_q[i] <= write_guard_pkg::PH_FREE;
        cnt_q[i] <= '0;
      end
      aw_cnt_q <= '0;
    end else begin
      for (int i = 0; i < num_slots; i++) begin
        if (aw_fire_i && (alloc_slot_i == write_guard_pkg::slot_idx_t'(i))) begin
          phase_q[i] <= write_guard_pkg::PH_DATA;
          cnt_q[i] <= '0;
        end else if (w_last_fire_i && (data_slot_i == write_guard_pkg::slot_idx_t'(i))) begin
          phase_q[i] <= write_guard_pkg::PH_RESP;
          cnt_q[i] <= '0;
        end else if (b_fire_i && !unexpected_b &&
                     (pop_slot_i == write_guard_pkg::slot_idx_t'(i))) begin
          phase_q[i] <= write_guard_pkg::PH_FREE;
          cnt_q[i] <= '0;
        end else if ((phase_q[i] != write_guard_pkg::PH_FREE) && (cnt_q[i] != '1)) begin
          // saturate so a maximum budget never expires
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
      if (!aw_pending_i) begin
        aw_cnt_q <= '0;
      end else if (aw_cnt_q != '1) begin
        aw_cnt_q <= aw_cnt_q + 1'b1;
      end
    end
  end

  // later hits override earlier ones, so the strongest report comes last
  always_comb begin
    write_guard_pkg::cnt_t slot_budget;
    fault_o = 1'b0;
    fault_kind_o = write_guard_pkg::FK_NONE;
    fault_info_o = '0;
    if (unexpected_b) begin
      fault_o = 1'b1;
      fault_kind_o = write_guard_pkg::FK_UNEXPECTED_B;
      fault_info_o.unexpected.id = b_id_i;
    end
    if (aw_cnt_q > budget_aw_i) begin
      fault_o = 1'b1;
      fault_kind_o = write_guard_pkg::FK_TIMEOUT;
      fault_info_o = '0;
      fault_info_o.timeout.aw_wait = 1'b1;
    end
    for (int i = num_slots - 1; i >= 0; i--) begin
      slot_budget = (phase_q[i] == write_guard_pkg::PH_DATA) ? budget_w_i : budget_b_i;
      if ((phase_q[i] != write_guard_pkg::PH_FREE) && (cnt_q[i] > slot_budget)) begin
        fault_o = 1'b1;
        fault_kind_o = write_guard_pkg::FK_TIMEOUT;
        fault_info_o = '0;
        fault_info_o.timeout.phase = phase_q[i];
        fault_info_o.timeout.slot = write_guard_pkg::slot_idx_t'(i);
      end
    end
  end

endmodule

`default_nettype wire

/* src/write_guard.sv */
// write_guard: top level joining id queue, order FIFO, watchdog and isolator
`default_nettype none

module write_guard (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         guard_ena_i,
  input  write_guard_pkg::cnt_t        budget_aw_i,
  input  write_guard_pkg::cnt_t        budget_w_i,
  input  write_guard_pkg::cnt_t        budget_b_i,
  input  logic                         aw_valid_i,
  input  write_guard_pkg::id_t         aw_id_i,
  output logic                         aw_ready_o,
  input  logic                         w_valid_i,
  input  logic                         w_last_i,
  output logic                         w_ready_o,
  output logic                         b_valid_o,
  output write_guard_pkg::id_t         b_id_o,
  input  logic                         b_ready_i,
  output logic                         slv_aw_valid_o,
  output write_guard_pkg::id_t         slv_aw_id_o,
  input  logic                         slv_aw_ready_i,
  output logic                         slv_w_valid_o,
  output logic                         slv_w_last_o,
  input  logic                         slv_w_ready_i,
  input  logic                         slv_b_valid_i,
  input  write_guard_pkg::id_t         slv_b_id_i,
  output logic                         slv_b_ready_o,
  output logic                         irq_o,
  output logic                         reset_req_o,
  output write_guard_pkg::fault_kind_t fault_kind_o,
  output write_guard_pkg::fault_info_u fault_info_o
);

  logic                         aw_pending, aw_fire, w_last_fire, b_fire;
  logic                         queue_full, order_empty, pop_hit, fault;
  write_guard_pkg::slot_idx_t   alloc_slot, pop_slot, data_slot;
  write_guard_pkg::fault_kind_t fault_kind;
  write_guard_pkg::fault_info_u fault_info;

  id_queue i_id_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (aw_fire),
    .push_id_i    (aw_id_i),
    .pop_i        (b_fire),
    .pop_id_i     (slv_b_id_i),
    .alloc_slot_o (alloc_slot),
    .full_o       (queue_full),
    .pop_hit_o    (pop_hit),
    .pop_slot_o   (pop_slot)
  );

  write_order_fifo i_write_order_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (aw_fire),
    .push_slot_i (alloc_slot),
    .pop_i       (w_last_fire),
    .head_slot_o (data_slot),
    .empty_o     (order_empty)
  );

  phase_watchdog i_phase_watchdog (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .aw_pending_i  (aw_pending),
    .aw_fire_i     (aw_fire),
    .alloc_slot_i  (alloc_slot),
    .w_last_fire_i (w_last_fire),
    .data_slot_i   (data_slot),
    .b_fire_i      (b_fire),
    .b_id_i        (slv_b_id_i),
    .pop_hit_i     (pop_hit),
    .pop_slot_i    (pop_slot),
    .budget_aw_i   (budget_aw_i),
    .budget_w_i    (budget_w_i),
    .budget_b_i    (budget_b_i),
    .fault_o       (fault),
    .fault_kind_o  (fault_kind),
    .fault_info_o  (fault_info)
  );

  fault_isolator i_fault_isolator (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .guard_ena_i    (guard_ena_i),
    .aw_valid_i     (aw_valid_i),
    .aw_id_i        (aw_id_i),
    .aw_ready_o     (aw_ready_o),
    .w_valid_i      (w_valid_i),
    .w_last_i       (w_last_i),
    .w_ready_o      (w_ready_o),
    .b_valid_o      (b_valid_o),
    .b_id_o         (b_id_o),
    .b_ready_i      (b_ready_i),
    .slv_aw_valid_o (slv_aw_valid_o),
    .slv_aw_id_o    (slv_aw_id_o),
    .slv_aw_ready_i (slv_aw_ready_i),
    .slv_w_valid_o  (slv_w_valid_o),
    .slv_w_last_o   (slv_w_last_o),
    .slv_w_ready_i  (slv_w_ready_i),
    .slv_b_valid_i  (slv_b_valid_i),
    .slv_b_id_i     (slv_b_id_i),
    .slv_b_ready_o  (slv_b_ready_o),
    .full_i         (queue_full),
    .order_empty_i  (order_empty),
    .fault_i        (fault),
    .fault_kind_i   (fault_kind),
    .fault_info_i   (fault_info),
    .aw_pending_o   (aw_pending),
    .aw_fire_o      (aw_fire),
    .w_last_fire_o  (w_last_fire),
    .b_fire_o       (b_fire),
    .irq_o          (irq_o),
    .reset_req_o    (reset_req_o),
    .fault_kind_o   (fault_kind_o),
    .fault_info_o   (fault_info_o)
  );

endmodule

`default_nettype wire

/* src/write_guard_pkg.sv */
// shared types: ids, slot index, counters, phase, fault kind and fault status union
`default_nettype none

`include "write_guard_settings.svh"

package write_guard_pkg;

  localparam int unsigned FaultInfoWidth = 8;
  localparam int unsigned SlotIdxWidth = $clog2(`WG_MAX_TXNS);

  typedef logic [`WG_ID_WIDTH-1:0] id_t;
  typedef logic [SlotIdxWidth-1:0] slot_idx_t;
  typedef logic [`WG_CNT_WIDTH-1:0] cnt_t;

  typedef enum logic [1:0] {
    PH_FREE = 2'd0,
    PH_DATA = 2'd1,
    PH_RESP = 2'd2
  } phase_t;

  typedef enum logic [1:0] {
    FK_NONE         = 2'd0,
    FK_TIMEOUT      = 2'd1,
    FK_UNEXPECTED_B = 2'd2
  } fault_kind_t;

  // phase is PH_FREE when the address wait expired
  typedef struct packed {
    phase_t                                  phase;
    logic                                    aw_wait;
    slot_idx_t                               slot;
    logic [FaultInfoWidth-SlotIdxWidth-4:0]  pad;
  } timeout_view_t;

  typedef struct packed {
    id_t                                 id;
    logic [FaultInfoWidth-`WG_ID_WIDTH-1:0] pad;
  } unexpected_view_t;

  // decoded according to the fault kind
  typedef union packed {
    timeout_view_t    timeout;
    unexpected_view_t unexpected;
  } fault_info_u;

endpackage

`default_nettype wire

/* src/write_guard_settings.svh */
// widths and depths for the write guard
`ifndef WRITE_GUARD_SETTINGS_SVH
`define WRITE_GUARD_SETTINGS_SVH

// transaction id width
`define WG_ID_WIDTH 4

// outstanding writes tracked at once
`define WG_MAX_TXNS 8

// distinct ids in flight, at most WG_MAX_TXNS
`define WG_MAX_IDS 4

// latency counter and budget width
`define WG_CNT_WIDTH 10

`endif

/* src/write_order_fifo.sv */
// write_order_fifo: slot indices in address order for attributing write data
`default_nettype none

`include "write_guard_settings.svh"

module write_order_fifo (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       push_i,
  input  write_guard_pkg::slot_idx_t push_slot_i,
  input  logic                       pop_i,
  output write_guard_pkg::slot_idx_t head_slot_o,
  output logic                       empty_o
);

  localparam int unsigned depth = `WG_MAX_TXNS;

  write_guard_pkg::slot_idx_t mem_q [depth];
  write_guard_pkg::slot_idx_t wr_ptr_q, rd_ptr_q;
  logic [$clog2(depth):0]     count_q;

  assign head_slot_o = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == write_guard_pkg::slot_idx_t'(depth - 1)) ? '0 :
                    wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == write_guard_pkg::slot_idx_t'(depth - 1)) ? '0 :
                    rd_ptr_q + 1'b1;
      end
      // push and pop together leave the count alone
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_slot_i;
    end
  end

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
// tb_clock_gen: 20 ns testbench clock and power-on reset
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int half_period = 10;

  initial begin
    clk_o = 1'b0;
    forever #half_period clk_o = ~clk_o;
  end

  // held low for ten rising edges, released on a falling edge
  initial begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* verification/write_guard_tb.sv */
// directed tests, master and slave models, compare tasks and cycle limit for the write guard
`default_nettype none

module write_guard_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // twice the length of six tests of at most ~250 cycles each
  localparam int max_cycles = 3000;
  localparam int hs_limit = 100;

  logic clk, gen_rst_n, rst_n, test_rst_n;
  logic guard_ena;
  write_guard_pkg::cnt_t budget_aw, budget_w, budget_b;
  logic aw_valid, w_valid, w_last, b_ready;
  logic slv_aw_ready, slv_w_ready, slv_b_valid;
  write_guard_pkg::id_t aw_id, slv_b_id;
  logic aw_ready_o, w_ready_o, b_valid_o, slv_aw_valid_o, slv_w_valid_o;
  logic slv_w_last_o, slv_b_ready_o, irq_o, reset_req_o;
  write_guard_pkg::id_t b_id_o, slv_aw_id_o;
  write_guard_pkg::fault_kind_t fault_kind_o;
  write_guard_pkg::fault_info_u fault_info_o;

  integer seed;
  logic [31:0] rnd;
  logic slave_auto;
  int cycle_count, checks, errors, test_err_base;
  string cur_test;

  assign rst_n = gen_rst_n & test_rst_n;

  tb_clock_gen i_clock_gen (.clk_o(clk), .rst_no(gen_rst_n));

  write_guard uut (
    .clk_i(clk), .rst_ni(rst_n), .guard_ena_i(guard_ena),
    .budget_aw_i(budget_aw), .budget_w_i(budget_w), .budget_b_i(budget_b),
    .aw_valid_i(aw_valid), .aw_id_i(aw_id), .aw_ready_o(aw_ready_o),
    .w_valid_i(w_valid), .w_last_i(w_last), .w_ready_o(w_ready_o),
    .b_valid_o(b_valid_o), .b_id_o(b_id_o), .b_ready_i(b_ready),
    .slv_aw_valid_o(slv_aw_valid_o), .slv_aw_id_o(slv_aw_id_o),
    .slv_aw_ready_i(slv_aw_ready), .slv_w_valid_o(slv_w_valid_o),
    .slv_w_last_o(slv_w_last_o), .slv_w_ready_i(slv_w_ready),
    .slv_b_valid_i(slv_b_valid), .slv_b_id_i(slv_b_id), .slv_b_ready_o(slv_b_ready_o),
    .irq_o(irq_o), .reset_req_o(reset_req_o),
    .fault_kind_o(fault_kind_o), .fault_info_o(fault_info_o)
  );

  // responsive slave with random ready delays
  always @(negedge clk) begin
    if (slave_auto) begin
      rnd = $random(seed);
      slv_aw_ready = rnd[0];
      slv_w_ready = rnd[1];
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic report_failure(input string msg);
    checks++;
    errors++;
    $display("%s: %s", cur_test, msg);
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch in %s, %s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  task automatic check_id(input string what, input write_guard_pkg::id_t exp,
                          input write_guard_pkg::id_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch in %s, %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_kind(input string what, input write_guard_pkg::fault_kind_t exp,
                            input write_guard_pkg::fault_kind_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch in %s, %s: expected %s, actual %s", cur_test, what,
               exp.name(), act.name());
    end
  endtask

  task automatic check_info(input string what, input write_guard_pkg::fault_info_u exp,
                            input write_guard_pkg::fault_info_u act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch in %s, %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_err_base = errors;
  endtask

  task automatic end_test();
    if (errors == test_err_base) begin
      $display("test %s: ok", cur_test);
    end else begin
      $display("test %s: %0d errors", cur_test, errors - test_err_base);
    end
  endtask

  // idle inputs and reset pulse before checking the reset state
  task automatic apply_reset(input logic ena, input write_guard_pkg::cnt_t aw_b,
                             input write_guard_pkg::cnt_t w_b, input write_guard_pkg::cnt_t b_b);
    @(negedge clk);
    slave_auto = 1'b0;
    test_rst_n = 1'b0;
    guard_ena = ena;
    budget_aw = aw_b;
    budget_w = w_b;
    budget_b = b_b;
    aw_valid = 1'b0;
    aw_id = '0;
    w_valid = 1'b0;
    w_last = 1'b0;
    b_ready = 1'b0;
    slv_aw_ready = 1'b0;
    slv_w_ready = 1'b0;
    slv_b_valid = 1'b0;
    slv_b_id = '0;
    repeat (10) @(negedge clk);
    test_rst_n = 1'b1;
    #5;
    check_bit("irq_o after reset", 1'b0, irq_o);
    check_bit("reset_req_o after reset", 1'b0, reset_req_o);
    check_kind("fault_kind_o after reset", write_guard_pkg::FK_NONE, fault_kind_o);
    check_bit("slv_aw_valid_o after reset", 1'b0, slv_aw_valid_o);
    check_bit("slv_b_ready_o after reset", 1'b0, slv_b_ready_o);
  endtask

  task automatic send_aw(input write_guard_pkg::id_t id);
    int waited;
    waited = 0;
    @(negedge clk);
    aw_valid = 1'b1;
    aw_id = id;
    #5;
    while (!aw_ready_o && waited < hs_limit) begin
      @(negedge clk);
      #5;
      waited++;
    end
    if (!aw_ready_o) begin
      report_failure("address handshake never completed");
    end else begin
      check_bit("slv_aw_valid_o at handshake", 1'b1, slv_aw_valid_o);
      check_id("slv_aw_id_o", id, slv_aw_id_o);
    end
    @(negedge clk);
    aw_valid = 1'b0;
  endtask

  // single-beat burst
  task automatic send_w();
    int waited;
    waited = 0;
    @(negedge clk);
    w_valid = 1'b1;
    w_last = 1'b1;
    #5;
    while (!w_ready_o && waited < hs_limit) begin
      @(negedge clk);
      #5;
      waited++;
    end
    if (!w_ready_o) begin
      report_failure("write data handshake never completed");
    end else begin
      check_bit("slv_w_valid_o at handshake", 1'b1, slv_w_valid_o);
      check_bit("slv_w_last_o", 1'b1, slv_w_last_o);
    end
    @(negedge clk);
    w_valid = 1'b0;
    w_last = 1'b0;
  endtask

  task automatic send_b(input write_guard_pkg::id_t id);
    int waited;
    waited = 0;
    @(negedge clk);
    slv_b_valid = 1'b1;
    slv_b_id = id;
    b_ready = 1'b1;
    #5;
    while (!(b_valid_o && slv_b_ready_o) && waited < hs_limit) begin
      @(negedge clk);
      #5;
      waited++;
    end
    if (!(b_valid_o && slv_b_ready_o)) begin
      report_failure("response handshake never completed");
    end else begin
      check_id("b_id_o", id, b_id_o);
    end
    @(negedge clk);
    slv_b_valid = 1'b0;
    b_ready = 1'b0;
  endtask

  // rising edges from the handshake edge until irq is seen
  task automatic wait_irq(output int lat);
    lat = 0;
    while (lat < 40) begin
      @(posedge clk);
      lat++;
      @(negedge clk);
      #5;
      if (irq_o) begin
        break;
      end
    end
    if (!irq_o) begin
      report_failure("irq_o never rose");
    end
  endtask

  task automatic test_normal_traffic();
    start_test("normal_traffic");
    apply_reset(1'b1, 10'd200, 10'd200, 10'd200);
    slave_auto = 1'b1;
    for (int i = 0; i < 8; i++) begin
      send_aw(write_guard_pkg::id_t'(i % 4));
    end
    for (int i = 0; i < 8; i++) begin
      send_w();
    end
    // per-id address order
    for (int i = 0; i < 8; i++) begin
      send_b(write_guard_pkg::id_t'(i % 4));
    end
    check_bit("irq_o", 1'b0, irq_o);
    check_kind("fault_kind_o", write_guard_pkg::FK_NONE, fault_kind_o);
    end_test();
  endtask

  task automatic test_back_pressure();
    start_test("back_pressure");
    apply_reset(1'b1, '1, '1, '1);
    @(negedge clk);
    slv_aw_ready = 1'b1;
    slv_w_ready = 1'b1;
    w_valid = 1'b1;
    w_last = 1'b1;
    #5;
    check_bit("w_ready_o with no address", 1'b0, w_ready_o);
    check_bit("slv_w_valid_o with no address", 1'b0, slv_w_valid_o);
    @(negedge clk);
    w_valid = 1'b0;
    w_last = 1'b0;
    for (int i = 0; i < 8; i++) begin
      send_aw(write_guard_pkg::id_t'(i % 4));
    end
    @(negedge clk);
    aw_valid = 1'b1;
    aw_id = 4'd1;
    repeat (3) begin
      #5;
      check_bit("aw_ready_o on ninth address", 1'b0, aw_ready_o);
      check_bit("slv_aw_valid_o on ninth address", 1'b0, slv_aw_valid_o);
      @(negedge clk);
    end
    aw_valid = 1'b0;
    check_bit("irq_o", 1'b0, irq_o);
    end_test();
  endtask

  task automatic test_resp_timeout();
    int lat;
    write_guard_pkg::fault_info_u exp;
    start_test("resp_timeout");
    apply_reset(1'b1, '1, '1, 10'd5);
    @(negedge clk);
    slv_aw_ready = 1'b1;
    slv_w_ready = 1'b1;
    send_aw(4'd2);
    send_w();
    wait_irq(lat);
    if (lat < 6 || lat > 8) begin
      report_failure($sformatf("irq_o rose %0d cycles after data, outside 6 to 8", lat));
    end
    exp = '0;
    exp.timeout.phase = write_guard_pkg::PH_RESP;
    exp.timeout.slot = '0;
    check_kind("fault_kind_o", write_guard_pkg::FK_TIMEOUT, fault_kind_o);
    check_info("fault_info_o", exp, fault_info_o);
    check_bit("reset_req_o", 1'b1, reset_req_o);
    @(negedge clk);
    slv_aw_ready = 1'b0;
    aw_valid = 1'b1;
    aw_id = 4'd3;
    repeat (3) begin
      #5;
      check_bit("slv_aw_valid_o isolated", 1'b0, slv_aw_valid_o);
      check_bit("aw_ready_o draining", 1'b1, aw_ready_o);
      @(negedge clk);
    end
    aw_valid = 1'b0;
    end_test();
  endtask

  task automatic test_unexpected_b();
    write_guard_pkg::fault_info_u exp;
    start_test("unexpected_b");
    apply_reset(1'b1, '1, '1, '1);
    send_b(4'd5);
    exp = '0;
    exp.unexpected.id = 4'd5;
    check_kind("fault_kind_o", write_guard_pkg::FK_UNEXPECTED_B, fault_kind_o);
    check_info("fault_info_o", exp, fault_info_o);
    check_bit("irq_o", 1'b1, irq_o);
    @(negedge clk);
    slv_b_valid = 1'b1;
    slv_b_id = 4'd5;
    #5;
    check_bit("b_valid_o isolated", 1'b0, b_valid_o);
    check_bit("slv_b_ready_o draining", 1'b1, slv_b_ready_o);
    @(negedge clk);
    slv_b_valid = 1'b0;
    end_test();
  endtask

  task automatic test_data_timeout();
    int lat;
    write_guard_pkg::fault_info_u exp;
    start_test("data_timeout");
    apply_reset(1'b1, '1, 10'd4, '1);
    @(negedge clk);
    slv_aw_ready = 1'b1;
    send_aw(4'd1);
    wait_irq(lat);
    if (lat < 5 || lat > 7) begin
      report_failure($sformatf("irq_o rose %0d cycles after address, outside 5 to 7", lat));
    end
    exp = '0;
    exp.timeout.phase = write_guard_pkg::PH_DATA;
    exp.timeout.slot = '0;
    check_kind("fault_kind_o", write_guard_pkg::FK_TIMEOUT, fault_kind_o);
    check_info("fault_info_o", exp, fault_info_o);
    end_test();
  endtask

  task automatic test_bypass();
    start_test("bypass");
    apply_reset(1'b0, '1, '1, 10'd5);
    @(negedge clk);
    slv_aw_ready = 1'b1;
    slv_w_ready = 1'b1;
    send_aw(4'd2);
    send_w();
    repeat (20) @(negedge clk);
    check_bit("irq_o", 1'b0, irq_o);
    check_bit("reset_req_o", 1'b0, reset_req_o);
    check_kind("fault_kind_o", write_guard_pkg::FK_NONE, fault_kind_o);
    aw_valid = 1'b1;
    aw_id = 4'd7;
    slv_aw_ready = 1'b0;
    w_valid = 1'b1;
    w_last = 1'b0;
    slv_b_valid = 1'b1;
    slv_b_id = 4'd9;
    b_ready = 1'b0;
    #5;
    check_bit("slv_aw_valid_o", 1'b1, slv_aw_valid_o);
    check_id("slv_aw_id_o", 4'd7, slv_aw_id_o);
    check_bit("aw_ready_o", 1'b0, aw_ready_o);
    check_bit("slv_w_valid_o", 1'b1, slv_w_valid_o);
    check_bit("slv_w_last_o", 1'b0, slv_w_last_o);
    check_bit("w_ready_o", 1'b1, w_ready_o);
    check_bit("b_valid_o", 1'b1, b_valid_o);
    check_id("b_id_o", 4'd9, b_id_o);
    check_bit("slv_b_ready_o", 1'b0, slv_b_ready_o);
    @(negedge clk);
    aw_valid = 1'b0;
    w_valid = 1'b0;
    slv_b_valid = 1'b0;
    end_test();
  endtask

  initial begin
    seed = 32'hed19_08da;
    cycle_count = 0;
    checks = 0;
    errors = 0;
    slave_auto = 1'b0;
    test_rst_n = 1'b1;
    guard_ena = 1'b0;
    budget_aw = '1;
    budget_w = '1;
    budget_b = '1;
    aw_valid = 1'b0;
    aw_id = '0;
    w_valid = 1'b0;
    w_last = 1'b0;
    b_ready = 1'b0;
    slv_aw_ready = 1'b0;
    slv_w_ready = 1'b0;
    slv_b_valid = 1'b0;
    slv_b_id = '0;
    wait (gen_rst_n === 1'b1);
    test_normal_traffic();
    test_back_pressure();
    test_resp_timeout();
    test_unexpected_b();
    test_data_timeout();
    test_bypass();
    $display("checks run: %0d, failed: %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* write_guard.f */
+incdir+src
src/write_guard_pkg.sv
src/id_queue.sv
src/write_order_fifo.sv
src/phase_watchdog.sv
src/fault_isolator.sv
src/write_guard.sv
verification/tb_clock_gen.sv
verification/write_guard_tb.sv
